/* axi_rd_interconnect.f */
+incdir+src
src/axi_rd_pkg.sv
src/rd_addr_decoder.sv
src/rd_slave_arbiter.sv
src/rd_data_return.sv
src/axi_rd_interconnect.sv
sim/axi_rd_slave_model.sv
sim/tb_axi_rd_interconnect.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the read interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f axi_rd_interconnect.f \
    --top-module tb_axi_rd_interconnect \
    --Mdir obj_dir -o tb_axi_rd_interconnect
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_axi_rd_interconnect > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1

/* sim/axi_rd_slave_model.sv */
`timescale 1ns/1ns
`include "axi_rd_cfg.svh"

module axi_rd_slave_model
    import axi_rd_pkg::*;
#(
    parameter int TAG = 1
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  ar_payload_t i_ar,
    input  logic        i_arvalid,
    output logic        o_arready,
    output r_payload_t  o_r,
    output logic        o_rvalid,
    input  logic        i_rready
);

    localparam logic [`AXI_DATA_W-1:0] DATA_TAG = (TAG == 1) ? 32'h5100_0000 : 32'h5200_0000;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_BURST} state_t;

    state_t                state;
    ar_payload_t           ar_q;
    logic                  ar_fire;
    logic                  r_fire;
    logic                  wait_cnt;
    logic [`AXI_LEN_W-1:0] beat;

    // Beat content depends on the address this slave actually received
    function automatic r_payload_t make_beat(input logic [`AXI_LEN_W-1:0] idx);
        r_payload_t r;
        r.id   = ar_q.id;
        r.data = (ar_q.addr + {{(`AXI_ADDR_W-`AXI_LEN_W){1'b0}}, idx}) ^ DATA_TAG;
        r.resp = RESP_OKAY;
        r.last = (idx == ar_q.len);
        return r;
    endfunction

    // Handshakes seen at the rising edge
    always @(posedge i_clk) begin
        if (i_rst) begin
            ar_fire <= 1'b0;
            r_fire  <= 1'b0;
        end else begin
            ar_fire <= i_arvalid && o_arready;
            r_fire  <= o_rvalid && i_rready;
            if (i_arvalid && o_arready) begin
                ar_q <= i_ar;
            end
        end
    end

    // Outputs move on the falling edge
    always @(negedge i_clk) begin
        if (i_rst) begin
            state     <= ST_IDLE;
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            o_r       <= '0;
            wait_cnt  <= 1'b0;
            beat      <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    o_arready <= !ar_fire;
                    if (ar_fire) begin
                        wait_cnt <= 1'b1;
                        state    <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (wait_cnt) begin
                        wait_cnt <= 1'b0;
                    end else begin
                        o_r      <= make_beat('0);
                        o_rvalid <= 1'b1;
                        beat     <= '0;
                        state    <= ST_BURST;
                    end
                end
                default: begin
                    // Next beat only after the current one was taken
                    if (r_fire && o_r.last) begin
                        o_rvalid  <= 1'b0;
                        o_r       <= '0;
                        o_arready <= 1'b1;
                        state     <= ST_IDLE;
                    end else if (r_fire) begin
                        o_r  <= make_beat(beat + 1'b1);
                        beat <= beat + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* sim/tb_axi_rd_interconnect.sv */
`timescale 1ns/1ns
`include "axi_rd_cfg.svh"

module tb_axi_rd_interconnect
    import axi_rd_pkg::*;
();

    localparam int NUM_ENTRIES = 8;

    // One table row holding both masters
    typedef struct packed {
        logic                   m1_en;
        logic [`AXI_ADDR_W-1:0] m1_addr;
        logic [`AXI_ID_W-1:0]   m1_id;
        logic [`AXI_LEN_W-1:0]  m1_len;
        logic                   m2_en;
        logic [`AXI_ADDR_W-1:0] m2_addr;
        logic [`AXI_ID_W-1:0]   m2_id;
        logic [`AXI_LEN_W-1:0]  m2_len;
    } stim_t;

    logic        clk;
    logic        rst;
    ar_payload_t m1_ar;
    ar_payload_t m2_ar;
    ar_payload_t s1_ar;
    ar_payload_t s2_ar;
    r_payload_t  m1_r;
    r_payload_t  m2_r;
    r_payload_t  s1_r;
    r_payload_t  s2_r;
    logic        m1_arvalid, m1_arready, m1_rvalid, m1_rready;
    logic        m2_arvalid, m2_arready, m2_rvalid, m2_rready;
    logic        s1_arvalid, s1_arready, s1_rvalid, s1_rready;
    logic        s2_arvalid, s2_arready, s2_rvalid, s2_rready;
    stim_t       stim [NUM_ENTRIES];
    time         first_beat_t [1:2];
    time         last_beat_t [1:2];
    integer      seed;

    axi_rd_interconnect dut0 (
        .i_clk(clk), .i_rst(rst),
        .i_m1_ar(m1_ar), .i_m1_arvalid(m1_arvalid), .o_m1_arready(m1_arready),
        .o_m1_r(m1_r), .o_m1_rvalid(m1_rvalid), .i_m1_rready(m1_rready),
        .i_m2_ar(m2_ar), .i_m2_arvalid(m2_arvalid), .o_m2_arready(m2_arready),
        .o_m2_r(m2_r), .o_m2_rvalid(m2_rvalid), .i_m2_rready(m2_rready),
        .o_s1_ar(s1_ar), .o_s1_arvalid(s1_arvalid), .i_s1_arready(s1_arready),
        .i_s1_r(s1_r), .i_s1_rvalid(s1_rvalid), .o_s1_rready(s1_rready),
        .o_s2_ar(s2_ar), .o_s2_arvalid(s2_arvalid), .i_s2_arready(s2_arready),
        .i_s2_r(s2_r), .i_s2_rvalid(s2_rvalid), .o_s2_rready(s2_rready)
    );

    axi_rd_slave_model #(.TAG(1)) slave1 (
        .i_clk(clk), .i_rst(rst), .i_ar(s1_ar), .i_arvalid(s1_arvalid),
        .o_arready(s1_arready), .o_r(s1_r), .o_rvalid(s1_rvalid), .i_rready(s1_rready)
    );

    axi_rd_slave_model #(.TAG(2)) slave2 (
        .i_clk(clk), .i_rst(rst), .i_ar(s2_ar), .i_arvalid(s2_arvalid),
        .o_arready(s2_arready), .o_r(s2_r), .o_rvalid(s2_rvalid), .i_rready(s2_rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_value(input logic [63:0] actual, input logic [63:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Stopped on first mismatch");
        end
    endtask

    // Upper half of the map goes to slave 2
    function automatic int target_slave(input logic [31:0] addr);
        return (addr >= 32'h8000_0000) ? 2 : 1;
    endfunction

    function automatic logic [31:0] expected_data(input logic [31:0] addr, input int beat);
        logic [31:0] slave_addr;
        logic [31:0] tag;
        slave_addr = (target_slave(addr) == 2) ? (addr & 32'h7FFF_FFFF) : addr;
        tag = (target_slave(addr) == 2) ? 32'h5200_0000 : 32'h5100_0000;
        return (slave_addr + 32'(beat)) ^ tag;
    endfunction

    function automatic int timeout_limit();
        int total;
        total = 0;
        foreach (stim[i]) begin
            if (stim[i].m1_en) begin
                total += int'(stim[i].m1_len) + 1 + 10;
            end
            if (stim[i].m2_en) begin
                total += int'(stim[i].m2_len) + 1 + 10;
            end
        end
        return 2 * total;
    endfunction

    task automatic drive_ar(input int m, input ar_payload_t ar, input logic valid);
        if (m == 1) begin
            m1_ar      = ar;
            m1_arvalid = valid;
        end else begin
            m2_ar      = ar;
            m2_arvalid = valid;
        end
    endtask

    // One full read for master m with every beat checked
    task automatic run_master(input int m, input logic [31:0] addr, input logic [7:0] id,
                              input logic [7:0] len);
        ar_payload_t ar;
        r_payload_t  r;
        logic        accepted;
        logic        fire;
        logic        done;
        int          beat;
        ar       = '0;
        ar.addr  = addr;
        ar.id    = id;
        ar.len   = len;
        ar.size  = 3'd2;
        ar.burst = 2'b01;
        @(negedge clk);
        drive_ar(m, ar, 1'b1);
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = (m == 1) ? (m1_arvalid && m1_arready) : (m2_arvalid && m2_arready);
        end
        @(negedge clk);
        drive_ar(m, '0, 1'b0);
        beat = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            fire = (m == 1) ? (m1_rvalid && m1_rready) : (m2_rvalid && m2_rready);
            r    = (m == 1) ? m1_r : m2_r;
            if (fire) begin
                compare_value(r.data, expected_data(addr, beat),
                              $sformatf("m%0d beat %0d data", m, beat));
                compare_value(r.id, id, $sformatf("m%0d beat %0d rid", m, beat));
                compare_value(r.resp, RESP_OKAY, $sformatf("m%0d beat %0d rresp", m, beat));
                compare_value(r.last, beat == int'(len),
                              $sformatf("m%0d beat %0d rlast", m, beat));
                if (beat == 0) begin
                    first_beat_t[m] = $time;
                end
                if (r.last) begin
                    done = 1'b1;
                    last_beat_t[m] = $time;
                end
                beat++;
            end
        end
    endtask

    task automatic check_idle();
        compare_value(m1_arready, 1'b0, "m1 arready after reset");
        compare_value(m1_rvalid, 1'b0, "m1 rvalid after reset");
        compare_value(m2_arready, 1'b0, "m2 arready after reset");
        compare_value(m2_rvalid, 1'b0, "m2 rvalid after reset");
        compare_value(s1_arvalid, 1'b0, "s1 arvalid after reset");
        compare_value(s1_rready, 1'b0, "s1 rready after reset");
        compare_value(s2_arvalid, 1'b0, "s2 arvalid after reset");
        compare_value(s2_rready, 1'b0, "s2 rready after reset");
    endtask

    // Random back-pressure on both masters
    initial begin
        seed      = 77;
        m1_rready = 1'b0;
        m2_rready = 1'b0;
        forever begin
            @(negedge clk);
            m1_rready = !rst && (($random(seed) % 4) != 0);
            m2_rready = !rst && (($random(seed) % 4) != 0);
        end
    end

    initial begin
        int limit;
        int cycles;
        @(negedge rst);
        limit  = timeout_limit();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the reads did not finish within %0d cycles", limit);
        $display("Simulation FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        rst        = 1'b1;
        m1_ar      = '0;
        m1_arvalid = 1'b0;
        m2_ar      = '0;
        m2_arvalid = 1'b0;
        // m1 en, addr, id, len, then m2 en, addr, id, len
        stim[0] = '{1'b1, 32'h0000_1000, 8'h11, 8'd3, 1'b0, 32'h0000_0000, 8'h00, 8'd0};
        stim[1] = '{1'b0, 32'h0000_0000, 8'h00, 8'd0, 1'b1, 32'h8000_2000, 8'h22, 8'd2};
        stim[2] = '{1'b1, 32'h0000_3000, 8'h31, 8'd4, 1'b1, 32'h0000_4000, 8'h42, 8'd2};
        stim[3] = '{1'b1, 32'h9000_0000, 8'h51, 8'd1, 1'b1, 32'hA000_0010, 8'h62, 8'd3};
        stim[4] = '{1'b1, 32'h0000_5000, 8'h71, 8'd7, 1'b1, 32'hC000_0100, 8'h82, 8'd5};
        stim[5] = '{1'b1, 32'hF000_0000, 8'h91, 8'd0, 1'b1, 32'h1234_5670, 8'hA2, 8'd6};
        stim[6] = '{1'b1, 32'h0001_0000, 8'hB1, 8'd15, 1'b1, 32'h8001_0000, 8'hC2, 8'd15};
        stim[7] = '{1'b0, 32'h0000_0000, 8'h00, 8'd0, 1'b1, 32'h7FFF_FFF0, 8'hD2, 8'd2};
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        check_idle();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            fork
                if (stim[i].m1_en)
                    run_master(1, stim[i].m1_addr, stim[i].m1_id, stim[i].m1_len);
                if (stim[i].m2_en)
                    run_master(2, stim[i].m2_addr, stim[i].m2_id, stim[i].m2_len);
            join
            // Same slave means master 1 owns it until its last beat
            if (stim[i].m1_en && stim[i].m2_en &&
                target_slave(stim[i].m1_addr) == target_slave(stim[i].m2_addr)) begin
                compare_value(first_beat_t[2] > last_beat_t[1], 1'b1,
                              $sformatf("entry %0d m2 data before m1 burst end", i));
            end
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* src/axi_rd_cfg.svh */
`ifndef AXI_RD_CFG_SVH
`define AXI_RD_CFG_SVH

// Bus field widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W   8
`define AXI_LEN_W  8

// AR sub-field widths
`define AXI_SIZE_W  3
`define AXI_BURST_W 2
`define AXI_CACHE_W 4
`define AXI_PROT_W  3
`define AXI_RESP_W  2

// Address map, slave 2 starts here and sees the top bit cleared
`define S1_ADDR_LIMIT 32'h8000_0000
`define S2_ADDR_MASK  32'h7FFF_FFFF

`endif

/* src/axi_rd_interconnect.sv */
`timescale 1ns/1ns
`include "axi_rd_cfg.svh"

module axi_rd_interconnect
    import axi_rd_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,

    // Master 1
    input  ar_payload_t i_m1_ar,
    input  logic        i_m1_arvalid,
    output logic        o_m1_arready,
    output r_payload_t  o_m1_r,
    output logic        o_m1_rvalid,
    input  logic        i_m1_rready,

    // Master 2
    input  ar_payload_t i_m2_ar,
    input  logic        i_m2_arvalid,
    output logic        o_m2_arready,
    output r_payload_t  o_m2_r,
    output logic        o_m2_rvalid,
    input  logic        i_m2_rready,

    // Slave 1
    output ar_payload_t o_s1_ar,
    output logic        o_s1_arvalid,
    input  logic        i_s1_arready,
    input  r_payload_t  i_s1_r,
    input  logic        i_s1_rvalid,
    output logic        o_s1_rready,

    // Slave 2
    output ar_payload_t o_s2_ar,
    output logic        o_s2_arvalid,
    input  logic        i_s2_arready,
    input  r_payload_t  i_s2_r,
    input  logic        i_s2_rvalid,
    output logic        o_s2_rready
);

    logic        m1_req_s1;
    logic        m1_req_s2;
    logic        m2_req_s1;
    logic        m2_req_s2;
    ar_payload_t m1_ar_dec;
    ar_payload_t m2_ar_dec;
    grant_t      s1_grant;
    grant_t      s2_grant;

    // Address decode per master
    rd_addr_decoder dec_m1 (
        .i_ar      (i_m1_ar),
        .i_arvalid (i_m1_arvalid),
        .o_req_s1  (m1_req_s1),
        .o_req_s2  (m1_req_s2),
        .o_ar      (m1_ar_dec)
    );

    rd_addr_decoder dec_m2 (
        .i_ar      (i_m2_ar),
        .i_arvalid (i_m2_arvalid),
        .o_req_s1  (m2_req_s1),
        .o_req_s2  (m2_req_s2),
        .o_ar      (m2_ar_dec)
    );

    // One arbiter per slave, each released by its own slave's last beat
    rd_slave_arbiter arb_s1 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_m1_req    (m1_req_s1),
        .i_m2_req    (m2_req_s1),
        .i_m1_ar     (m1_ar_dec),
        .i_m2_ar     (m2_ar_dec),
        .i_m1_rready (i_m1_rready),
        .i_m2_rready (i_m2_rready),
        .i_rvalid    (i_s1_rvalid),
        .i_rlast     (i_s1_r.last),
        .o_ar        (o_s1_ar),
        .o_arvalid   (o_s1_arvalid),
        .o_rready    (o_s1_rready),
        .o_grant     (s1_grant)
    );

    rd_slave_arbiter arb_s2 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_m1_req    (m1_req_s2),
        .i_m2_req    (m2_req_s2),
        .i_m1_ar     (m1_ar_dec),
        .i_m2_ar     (m2_ar_dec),
        .i_m1_rready (i_m1_rready),
        .i_m2_rready (i_m2_rready),
        .i_rvalid    (i_s2_rvalid),
        .i_rlast     (i_s2_r.last),
        .o_ar        (o_s2_ar),
        .o_arvalid   (o_s2_arvalid),
        .o_rready    (o_s2_rready),
        .o_grant     (s2_grant)
    );

    // Response routing back to each master
    rd_data_return #(
        .MASTER_SEL (GRANT_M1)
    ) ret_m1 (
        .i_s1_grant   (s1_grant),
        .i_s2_grant   (s2_grant),
        .i_s1_arready (i_s1_arready),
        .i_s2_arready (i_s2_arready),
        .i_s1_r       (i_s1_r),
        .i_s2_r       (i_s2_r),
        .i_s1_rvalid  (i_s1_rvalid),
        .i_s2_rvalid  (i_s2_rvalid),
        .o_arready    (o_m1_arready),
        .o_r          (o_m1_r),
        .o_rvalid     (o_m1_rvalid)
    );

    rd_data_return #(
        .MASTER_SEL (GRANT_M2)
    ) ret_m2 (
        .i_s1_grant   (s1_grant),
        .i_s2_grant   (s2_grant),
        .i_s1_arready (i_s1_arready),
        .i_s2_arready (i_s2_arready),
        .i_s1_r       (i_s1_r),
        .i_s2_r       (i_s2_r),
        .i_s1_rvalid  (i_s1_rvalid),
        .i_s2_rvalid  (i_s2_rvalid),
        .o_arready    (o_m2_arready),
        .o_r          (o_m2_r),
        .o_rvalid     (o_m2_rvalid)
    );

endmodule

/* src/axi_rd_pkg.sv */
`include "axi_rd_cfg.svh"

package axi_rd_pkg;

    // Read address channel fields, valid and ready travel separately
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0]  addr;
        logic [`AXI_ID_W-1:0]    id;
        logic [`AXI_LEN_W-1:0]   len;
        logic [`AXI_SIZE_W-1:0]  size;
        logic [`AXI_BURST_W-1:0] burst;
        logic                    lock;
        logic [`AXI_CACHE_W-1:0] cache;
        logic [`AXI_PROT_W-1:0]  prot;
    } ar_payload_t;

    // Read data channel fields
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_RESP_W-1:0] resp;
        logic                   last;
    } r_payload_t;

    // One-hot master select held by each slave arbiter
    typedef enum logic [1:0] {
        GRANT_NONE = 2'b00,
        GRANT_M1   = 2'b01,
        GRANT_M2   = 2'b10
    } grant_t;

    // Normal access response
    localparam logic [`AXI_RESP_W-1:0] RESP_OKAY = 2'b00;

endpackage

/* src/rd_addr_decoder.sv */
`timescale 1ns/1ns
`include "axi_rd_cfg.svh"

module rd_addr_decoder
    import axi_rd_pkg::*;
(
    input  ar_payload_t i_ar,
    input  logic        i_arvalid,
    output logic        o_req_s1,
    output logic        o_req_s2,
    output ar_payload_t o_ar
);

    logic hit_s2;

    // Upper half of the map belongs to slave 2
    assign hit_s2 = (i_ar.addr >= `S1_ADDR_LIMIT);

    // Requests only while the master presents a valid address
    assign o_req_s1 = i_arvalid && !hit_s2;
    assign o_req_s2 = i_arvalid && hit_s2;

    // Slave 2 sees its own zero-based address
    always_comb begin
        o_ar = i_ar;
        if (hit_s2) begin
            o_ar.addr = i_ar.addr & `S2_ADDR_MASK;
        end
    end

endmodule

/* src/rd_data_return.sv */
`timescale 1ns/1ns
`include "axi_rd_cfg.svh"

module rd_data_return
    import axi_rd_pkg::*;
#(
    parameter grant_t MASTER_SEL = GRANT_M1
) (
    // Grant state of both slave arbiters
    input  grant_t     i_s1_grant,
    input  grant_t     i_s2_grant,

    // Slave side responses
    input  logic       i_s1_arready,
    input  logic       i_s2_arready,
    input  r_payload_t i_s1_r,
    input  r_payload_t i_s2_r,
    input  logic       i_s1_rvalid,
    input  logic       i_s2_rvalid,

    // Toward this master
    output logic       o_arready,
    output r_payload_t o_r,
    output logic       o_rvalid
);

    logic from_s1;
    logic from_s2;

    // Which slave currently serves this master
    assign from_s1 = (i_s1_grant == MASTER_SEL);
    assign from_s2 = (i_s2_grant == MASTER_SEL);

    // Pure combinational path, no beat is held here
    always_comb begin
        o_arready = 1'b0;
        o_r       = '0;
        o_rvalid  = 1'b0;
        if (from_s1) begin
            o_arready = i_s1_arready;
            o_r       = i_s1_r;
            o_rvalid  = i_s1_rvalid;
        end else if (from_s2) begin
            o_arready = i_s2_arready;
            o_r       = i_s2_r;
            o_rvalid  = i_s2_rvalid;
        end
    end

endmodule

/* src/rd_slave_arbiter.sv */
`timescale 1ns/1ns
`include "axi_rd_cfg.svh"

module rd_slave_arbiter
    import axi_rd_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,

    // Requests and payloads from both decoders
    input  logic        i_m1_req,
    input  logic        i_m2_req,
    input  ar_payload_t i_m1_ar,
    input  ar_payload_t i_m2_ar,
    input  logic        i_m1_rready,
    input  logic        i_m2_rready,

    // Read data status from the slave
    input  logic        i_rvalid,
    input  logic        i_rlast,

    // Toward the slave
    output ar_payload_t o_ar,
    output logic        o_arvalid,
    output logic        o_rready,
    output grant_t      o_grant
);

    grant_t grant_q;
    logic   burst_done;

    // Final beat handshake at the slave ends the grant
    assign burst_done = i_rvalid && o_rready && i_rlast;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            grant_q <= GRANT_NONE;
        end else begin
            case (grant_q)
                GRANT_NONE: begin
                    // Master 1 wins a tie
                    if (i_m1_req) begin
                        grant_q <= GRANT_M1;
                    end else if (i_m2_req) begin
                        grant_q <= GRANT_M2;
                    end
                end
                default: begin
                    if (burst_done) begin
                        grant_q <= GRANT_NONE;
                    end
                end
            endcase
        end
    end

    // Steer the granted master to the slave
    always_comb begin
        o_ar      = '0;
        o_arvalid = 1'b0;
        o_rready  = 1'b0;
        case (grant_q)
            GRANT_M1: begin
                o_ar      = i_m1_ar;
                o_arvalid = i_m1_req;
                o_rready  = i_m1_rready;
            end
            GRANT_M2: begin
                o_ar      = i_m2_ar;
                o_arvalid = i_m2_req;
                o_rready  = i_m2_rready;
            end
            default: begin
                // Idle, slave sees nothing
                o_ar      = '0;
                o_arvalid = 1'b0;
                o_rready  = 1'b0;
            end
        endcase
    end

    assign o_grant = grant_q;

endmodule
